// ==== design/xge_rx_pkg.sv ====
package xge_rx_pkg;

    ////////////////////////////////////////////////////////////
    // Lane sizing
    ////////////////////////////////////////////////////////////

    // Upper bound on physical and logical lanes
    localparam int LANES_MAX  = 4;
    localparam int LANE_IDX_W = $clog2(LANES_MAX);

    ////////////////////////////////////////////////////////////
    // 64b/66b sync headers and block types
    ////////////////////////////////////////////////////////////

    localparam logic [1:0] HDR_DATA = 2'b01;
    localparam logic [1:0] HDR_CTRL = 2'b10;

    // Block type sits in the first payload byte
    localparam logic [7:0] TYPE_IDLE   = 8'h1E;
    // Logical lane number in the low bits of the byte after the type
    localparam logic [7:0] TYPE_MARKER = 8'hA5;

    // XGMII control characters
    localparam logic [7:0] CHAR_IDLE  = 8'h07;
    localparam logic [7:0] CHAR_ERROR = 8'hFE;

    ////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////

    // One received 66-bit block plus its strobe
    typedef struct packed {
        logic        valid;
        logic [1:0]  header;
        logic [63:0] payload;
    } block_t;

    // One decoded XGMII word, rxc bit per byte
    typedef struct packed {
        logic [7:0]  rxc;
        logic [63:0] rxd;
    } xgmii_t;

endpackage

// ==== design/lane_reorder.sv ====
`timescale 1ns/1ps

module lane_reorder #(
    parameter int NUM_LANES = 4
) (
    input  logic               clk_156_i,
    input  logic               rst_n_i,
    input  xge_rx_pkg::block_t phys_blocks_i [NUM_LANES],
    output xge_rx_pkg::block_t lane_blocks_o [NUM_LANES]
);

    import xge_rx_pkg::*;

    // Physical source for each logical lane
    logic [LANE_IDX_W-1:0] src_sel_q [NUM_LANES];

    // Marker decode per physical lane
    logic                  mark_hit  [NUM_LANES];
    logic [LANE_IDX_W-1:0] mark_lane [NUM_LANES];

    // Block picked for each logical lane
    block_t                sel_blk   [NUM_LANES];

    ////////////////////////////////////////////////////////////
    // Alignment marker detection
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int p = 0; p < NUM_LANES; p++) begin
            mark_hit[p]  = phys_blocks_i[p].valid
                        && (phys_blocks_i[p].header == HDR_CTRL)
                        && (phys_blocks_i[p].payload[7:0] == TYPE_MARKER);
            mark_lane[p] = phys_blocks_i[p].payload[8 +: LANE_IDX_W];
        end
    end

    // Identity after reset, marker rewrites one entry
    always_ff @(posedge clk_156_i) begin
        if (!rst_n_i) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                src_sel_q[l] <= LANE_IDX_W'(l);
            end
        end else begin
            for (int p = 0; p < NUM_LANES; p++) begin
                // Lane numbers beyond the configured count are ignored
                if (mark_hit[p] && (int'(mark_lane[p]) < NUM_LANES)) begin
                    src_sel_q[mark_lane[p]] <= LANE_IDX_W'(p);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Lane crossbar and output register
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            sel_blk[l] = phys_blocks_i[src_sel_q[l]];
        end
    end

    always_ff @(posedge clk_156_i) begin
        for (int l = 0; l < NUM_LANES; l++) begin
            if (!rst_n_i) begin
                lane_blocks_o[l].valid <= 1'b0;
            end else begin
                lane_blocks_o[l].valid <= sel_blk[l].valid;
            end
            lane_blocks_o[l].header  <= sel_blk[l].header;
            lane_blocks_o[l].payload <= sel_blk[l].payload;
        end
    end

    // A marker must name a known lane, or the map goes to X
    for (genvar p = 0; p < NUM_LANES; p++) begin : g_mark_chk
        a_mark_lane_known : assert property (
            @(posedge clk_156_i) disable iff (!rst_n_i)
            mark_hit[p] |-> !$isunknown(phys_blocks_i[p].payload[8 +: LANE_IDX_W])
        );
    end

endmodule

// ==== design/lane_receiver.sv ====
`timescale 1ns/1ps

module lane_receiver #(
    parameter int LOCK_COUNT = 64,
    parameter int BAD_LIMIT  = 16
) (
    input  logic               clk_156_i,
    input  logic               rst_n_i,
    input  xge_rx_pkg::block_t block_i,
    input  logic               clear_errblk_i,
    output xge_rx_pkg::xgmii_t xgmii_o,
    output logic               blk_lock_o,
    output logic [7:0]         errd_blks_o
);

    import xge_rx_pkg::*;

    localparam int GOOD_W = $clog2(LOCK_COUNT + 1);
    localparam int BAD_W  = $clog2(BAD_LIMIT + 1);

    localparam xgmii_t XGMII_ERROR = '{rxc: 8'hFF, rxd: {8{CHAR_ERROR}}};
    localparam xgmii_t XGMII_IDLE  = '{rxc: 8'hFF, rxd: {8{CHAR_IDLE}}};

    // Lock state
    logic              lock_q;
    logic [GOOD_W-1:0] good_cnt_q;
    logic [BAD_W-1:0]  bad_cnt_q;

    // Valid blocks seen since the last loss of lock
    logic [GOOD_W-1:0] since_loss_q;

    logic [7:0]        errd_q;
    xgmii_t            word_d;
    xgmii_t            word_q;

    // Block classification, shared by lock and decode
    logic       hdr_ok;
    logic       blk_good;
    logic       blk_bad;
    logic       lock_done;
    logic       lock_lost;
    logic [7:0] blk_type;

    assign hdr_ok    = (block_i.header == HDR_DATA) || (block_i.header == HDR_CTRL);
    assign blk_good  = block_i.valid && hdr_ok;
    assign blk_bad   = block_i.valid && !hdr_ok;
    assign blk_type  = block_i.payload[7:0];
    assign lock_done = !lock_q && blk_good && (good_cnt_q == GOOD_W'(LOCK_COUNT - 1));
    assign lock_lost = lock_q && blk_bad && (bad_cnt_q == BAD_W'(BAD_LIMIT - 1));

    ////////////////////////////////////////////////////////////
    // Block lock
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_156_i) begin
        if (!rst_n_i) begin
            lock_q <= 1'b0;
        end else if (lock_done) begin
            lock_q <= 1'b1;
        end else if (lock_lost) begin
            lock_q <= 1'b0;
        end
    end

    // Run of good headers while hunting
    always_ff @(posedge clk_156_i) begin
        if (!rst_n_i) begin
            good_cnt_q <= '0;
        end else if (lock_q || blk_bad || lock_done) begin
            good_cnt_q <= '0;
        end else if (blk_good) begin
            good_cnt_q <= good_cnt_q + 1'b1;
        end
    end

    // Run of bad headers while locked
    always_ff @(posedge clk_156_i) begin
        if (!rst_n_i) begin
            bad_cnt_q <= '0;
        end else if (!lock_q || blk_good || lock_lost) begin
            bad_cnt_q <= '0;
        end else if (blk_bad) begin
            bad_cnt_q <= bad_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_156_i) begin
        if (!rst_n_i || lock_lost) begin
            since_loss_q <= '0;
        end else if (block_i.valid && (since_loss_q != GOOD_W'(LOCK_COUNT))) begin
            since_loss_q <= since_loss_q + 1'b1;
        end
    end

    // Errored blocks, clear wins over count
    always_ff @(posedge clk_156_i) begin
        if (!rst_n_i || clear_errblk_i) begin
            errd_q <= '0;
        end else if (lock_q && blk_bad && (errd_q != 8'hFF)) begin
            errd_q <= errd_q + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Decoder
    ////////////////////////////////////////////////////////////

    always_comb begin
        word_d = XGMII_ERROR;
        if (lock_q && (block_i.header == HDR_DATA)) begin
            word_d.rxc = '0;
            word_d.rxd = block_i.payload;
        end else if (lock_q && (block_i.header == HDR_CTRL)) begin
            if ((blk_type == TYPE_IDLE) || (blk_type == TYPE_MARKER)) begin
                word_d = XGMII_IDLE;
            end
        end
    end

    // Hold last word on empty cycles
    always_ff @(posedge clk_156_i) begin
        if (!rst_n_i) begin
            word_q <= XGMII_ERROR;
        end else if (block_i.valid) begin
            word_q <= word_d;
        end
    end

    assign xgmii_o     = word_q;
    assign blk_lock_o  = lock_q;
    assign errd_blks_o = errd_q;

    a_errd_monotonic : assert property (
        @(posedge clk_156_i) disable iff (!rst_n_i)
        !clear_errblk_i |=> (errd_blks_o >= $past(errd_blks_o))
    );

    a_lock_needs_run : assert property (
        @(posedge clk_156_i) disable iff (!rst_n_i)
        $rose(blk_lock_o) |-> (since_loss_q >= GOOD_W'(LOCK_COUNT))
    );

endmodule

// ==== design/xge_rx_top.sv ====
`timescale 1ns/1ps

module xge_rx_top #(
    parameter int NUM_LANES  = 4,
    parameter int LOCK_COUNT = 64,
    parameter int BAD_LIMIT  = 16
) (
    input  logic                 clk_156_i,
    input  logic                 rst_n_i,
    input  xge_rx_pkg::block_t   rx_blocks_i [NUM_LANES],
    input  logic                 clear_errblk_i,
    output xge_rx_pkg::xgmii_t   xgmii_o [NUM_LANES],
    output logic [NUM_LANES-1:0] blk_lock_o,
    output logic [7:0]           errd_blks_o [NUM_LANES]
);

    import xge_rx_pkg::*;

    // Blocks in logical lane order
    block_t lane_blocks [NUM_LANES];

    lane_reorder #(
        .NUM_LANES (NUM_LANES)
    ) u_lane_reorder (
        .clk_156_i     (clk_156_i),
        .rst_n_i       (rst_n_i),
        .phys_blocks_i (rx_blocks_i),
        .lane_blocks_o (lane_blocks)
    );

    ////////////////////////////////////////////////////////////
    // One receiver per logical lane
    ////////////////////////////////////////////////////////////

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        lane_receiver #(
            .LOCK_COUNT (LOCK_COUNT),
            .BAD_LIMIT  (BAD_LIMIT)
        ) u_lane_receiver (
            .clk_156_i      (clk_156_i),
            .rst_n_i        (rst_n_i),
            .block_i        (lane_blocks[g]),
            .clear_errblk_i (clear_errblk_i),
            .xgmii_o        (xgmii_o[g]),
            .blk_lock_o     (blk_lock_o[g]),
            .errd_blks_o    (errd_blks_o[g])
        );
    end

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 20.0,
    parameter int  RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // Released on a rising edge, like the rest of the stimulus
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// ==== verification/xge_rx_tb.sv ====
`timescale 1ns/1ps

module xge_rx_tb;

    import xge_rx_pkg::*;

    localparam int          NUM_LANES      = 4;
    localparam int          LOCK_COUNT     = 64;
    localparam int          BAD_LIMIT      = 16;
    localparam real         CLK_PERIOD_NS  = 20.0;
    localparam logic [31:0] SEED           = 32'd7208;
    // Stimulus below runs about 720 cycles, limit leaves ample margin
    localparam int          TIMEOUT_CYCLES = 2000;

    // Stimulus kinds
    localparam int K_DATA  = 0;
    localparam int K_IDLE  = 1;
    localparam int K_OTHER = 2;
    localparam int K_BAD   = 3;
    localparam int K_EMPTY = 4;
    localparam int K_VALID = 5;
    localparam int K_MIX   = 6;

    localparam xgmii_t WORD_ERROR = '{rxc: 8'hFF, rxd: {8{CHAR_ERROR}}};
    localparam xgmii_t WORD_IDLE  = '{rxc: 8'hFF, rxd: {8{CHAR_IDLE}}};

    logic                 clk_156;
    logic                 rst_n;
    block_t               rx_blocks [NUM_LANES];
    logic                 clear_errblk;
    xgmii_t               xgmii     [NUM_LANES];
    logic [NUM_LANES-1:0] blk_lock;
    logic [7:0]           errd_blks [NUM_LANES];

    // Reference model state
    logic [LANE_IDX_W-1:0] lane_map [NUM_LANES];
    block_t                stage_q  [NUM_LANES];
    int                    good_run [NUM_LANES];
    int                    bad_run  [NUM_LANES];
    logic [NUM_LANES-1:0]  exp_lock;
    xgmii_t                exp_word [NUM_LANES];
    logic [7:0]            exp_err  [NUM_LANES];

    logic [31:0] rng_state  = SEED;
    int          cycle_cnt  = 0;
    int          word_errs  = 0;
    int          lock_errs  = 0;
    int          count_errs = 0;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (4)
    ) u_clock_gen (
        .clk_o   (clk_156),
        .rst_n_o (rst_n)
    );

    xge_rx_top UUT (
        .clk_156_i      (clk_156),
        .rst_n_i        (rst_n),
        .rx_blocks_i    (rx_blocks),
        .clear_errblk_i (clear_errblk),
        .xgmii_o        (xgmii),
        .blk_lock_o     (blk_lock),
        .errd_blks_o    (errd_blks)
    );

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic block_t make_block(input int kind);
        block_t      b;
        int          k;
        logic [31:0] hi;
        logic [31:0] lo;
        k = kind;
        if (kind == K_VALID) begin
            k = int'(xorshift32() % 3);
        end else if (kind == K_MIX) begin
            k = int'(xorshift32() % 4);
            k = (k == 3) ? K_EMPTY : k;
        end
        hi = xorshift32();
        lo = xorshift32();
        b.valid   = (k != K_EMPTY);
        b.header  = HDR_DATA;
        b.payload = {hi, lo};
        case (k)
            K_IDLE: begin
                b.header       = HDR_CTRL;
                b.payload[7:0] = TYPE_IDLE;
            end
            // Types 40 to 7F never hit idle or marker
            K_OTHER: begin
                b.header       = HDR_CTRL;
                b.payload[7:0] = {2'b01, hi[5:0]};
            end
            // Headers 00 and 11
            K_BAD: b.header = {2{hi[0]}};
            default: ;
        endcase
        return b;
    endfunction

    task automatic drive_cycles(input int kind, input int count);
        for (int c = 0; c < count; c++) begin
            @(posedge clk_156);
            for (int p = 0; p < NUM_LANES; p++) begin
                rx_blocks[p] <= make_block(kind);
            end
        end
    endtask

    // Physical lane p carries logical lane NUM_LANES-1-p
    task automatic send_reverse_markers();
        block_t b;
        @(posedge clk_156);
        for (int p = 0; p < NUM_LANES; p++) begin
            b = make_block(K_IDLE);
            b.payload[7:0]              = TYPE_MARKER;
            b.payload[8 +: LANE_IDX_W] = LANE_IDX_W'(NUM_LANES - 1 - p);
            rx_blocks[p] <= b;
        end
    endtask

    // Keeps valid traffic going until every lane reports lock
    task automatic wait_lock();
        while (blk_lock != '1) begin
            drive_cycles(K_VALID, 1);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    task automatic predict_lane(input int l);
        block_t b;
        logic   hdr_good;
        b        = stage_q[l];
        hdr_good = (b.header == HDR_DATA) || (b.header == HDR_CTRL);
        if (b.valid) begin
            exp_word[l] = WORD_ERROR;
            if (exp_lock[l] && (b.header == HDR_DATA)) begin
                exp_word[l].rxc = 8'h00;
                exp_word[l].rxd = b.payload;
            end else if (exp_lock[l] && (b.header == HDR_CTRL)
                         && ((b.payload[7:0] == TYPE_IDLE) || (b.payload[7:0] == TYPE_MARKER))) begin
                exp_word[l] = WORD_IDLE;
            end
            if (exp_lock[l] && hdr_good) begin
                bad_run[l] = 0;
            end else if (exp_lock[l]) begin
                exp_err[l] = (exp_err[l] == 8'hFF) ? 8'hFF : exp_err[l] + 8'd1;
                bad_run[l]++;
                if (bad_run[l] == BAD_LIMIT) begin
                    exp_lock[l] = 1'b0;
                    bad_run[l]  = 0;
                end
            end else if (hdr_good) begin
                good_run[l]++;
                if (good_run[l] == LOCK_COUNT) begin
                    exp_lock[l] = 1'b1;
                    good_run[l] = 0;
                end
            end else begin
                good_run[l] = 0;
            end
        end
        if (clear_errblk) begin
            exp_err[l] = 8'h00;
        end
    endtask

    // Receivers first, then the reorder register, then the lane map
    always @(posedge clk_156) begin
        if (!rst_n) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                lane_map[l] = LANE_IDX_W'(l);
                stage_q[l]  = '0;
                good_run[l] = 0;
                bad_run[l]  = 0;
                exp_word[l] = WORD_ERROR;
                exp_err[l]  = 8'h00;
            end
            exp_lock = '0;
        end else begin
            for (int l = 0; l < NUM_LANES; l++) begin
                predict_lane(l);
            end
            for (int l = 0; l < NUM_LANES; l++) begin
                stage_q[l] = rx_blocks[lane_map[l]];
            end
            for (int p = 0; p < NUM_LANES; p++) begin
                if (rx_blocks[p].valid && (rx_blocks[p].header == HDR_CTRL)
                    && (rx_blocks[p].payload[7:0] == TYPE_MARKER)) begin
                    lane_map[rx_blocks[p].payload[8 +: LANE_IDX_W]] = LANE_IDX_W'(p);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_chk
        a_word : assert property (@(posedge clk_156) disable iff (!rst_n)
            xgmii[g] == exp_word[g])
        else begin
            word_errs++;
            $display("Error %0t: xgmii_o[%0d] expected %h got %h", $time, g,
                     $sampled(exp_word[g]), $sampled(xgmii[g]));
        end

        a_lock : assert property (@(posedge clk_156) disable iff (!rst_n)
            blk_lock[g] == exp_lock[g])
        else begin
            lock_errs++;
            $display("Error %0t: blk_lock_o[%0d] expected %b got %b", $time, g,
                     $sampled(exp_lock[g]), $sampled(blk_lock[g]));
        end

        a_count : assert property (@(posedge clk_156) disable iff (!rst_n)
            errd_blks[g] == exp_err[g])
        else begin
            count_errs++;
            $display("Error %0t: errd_blks_o[%0d] expected %0d got %0d", $time, g,
                     $sampled(exp_err[g]), $sampled(errd_blks[g]));
        end
    end

    always @(posedge clk_156) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("Timeout: stimulus still running after %0d cycles", cycle_cnt);
        $display("*** FAILED ***");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        for (int p = 0; p < NUM_LANES; p++) begin
            rx_blocks[p] = '0;
        end
        clear_errblk = 1'b0;
        @(posedge clk_156);
        while (!rst_n) begin
            @(posedge clk_156);
        end
        drive_cycles(K_EMPTY, 4);
        drive_cycles(K_VALID, LOCK_COUNT);
        wait_lock();
        drive_cycles(K_MIX, 100);
        send_reverse_markers();
        drive_cycles(K_MIX, 100);
        // Errored blocks and counter clear
        drive_cycles(K_BAD, 5);
        drive_cycles(K_DATA, 3);
        clear_errblk <= 1'b1;
        drive_cycles(K_BAD, 3);
        clear_errblk <= 1'b0;
        drive_cycles(K_DATA, 2);
        // Loss of lock, then bad blocks while hunting
        drive_cycles(K_BAD, BAD_LIMIT + 4);
        drive_cycles(K_VALID, LOCK_COUNT);
        wait_lock();
        // Bad runs kept short of BAD_LIMIT until the count saturates
        for (int i = 0; i < 18; i++) begin
            drive_cycles(K_BAD, BAD_LIMIT - 1);
            drive_cycles(K_DATA, 1);
        end
        drive_cycles(K_MIX, 20);
        drive_cycles(K_EMPTY, 4);
        $display("Errors: word %0d, lock %0d, count %0d", word_errs, lock_errs, count_errs);
        if ((word_errs + lock_errs + count_errs) == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== xge_rx_top.f ====
design/xge_rx_pkg.sv
design/lane_reorder.sv
design/lane_receiver.sv
design/xge_rx_top.sv
verification/tb_clock_gen.sv
verification/xge_rx_tb.sv

// ==== Bender.yml ====
package:
  name: xge_rx

sources:
  # Receive path RTL, package first
  - design/xge_rx_pkg.sv
  - design/lane_reorder.sv
  - design/lane_receiver.sv
  - design/xge_rx_top.sv
  # Simulation only
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/xge_rx_tb.sv
